// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - source

sources:
  - source/lsu_pkg.sv
  - source/hold_slice.sv
  - source/load_align.sv
  - source/lsu_axi_master.sv
  - source/data_ram_axil.sv
  - source/lsu_top.sv
  - target: test
    files:
      - verif/lsu_tb.sv

// ==== source/data_ram_axil.sv ====
// AXI4-Lite slave word memory with byte strobes and an out-of-range SLVERR
`timescale 1ns/1ns
`include "lsu_defines.svh"

module data_ram_axil (
	input  logic                     clock,
	input  logic                     rstn,

	input  logic [`LSU_ADDR_LEN-1:0] awaddr_i,
	input  logic                     awvalid_i,
	output logic                     awready_o,

	input  logic [`LSU_DATA_LEN-1:0] wdata_i,
	input  logic [`LSU_STRB_LEN-1:0] wstrb_i,
	input  logic                     wvalid_i,
	output logic                     wready_o,

	output lsu_pkg::axi_resp_e       bresp_o,
	output logic                     bvalid_o,
	input  logic                     bready_i,

	input  logic [`LSU_ADDR_LEN-1:0] araddr_i,
	input  logic                     arvalid_i,
	output logic                     arready_o,

	output logic [`LSU_DATA_LEN-1:0] rdata_o,
	output lsu_pkg::axi_resp_e       rresp_o,
	output logic                     rvalid_o,
	input  logic                     rready_i
);

	localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

	logic [`LSU_DATA_LEN-1:0] mem_q [`LSU_MEM_WORDS];
	logic                     wr_hs;
	logic                     rd_hs;
	logic                     wr_in_range;
	logic                     rd_in_range;
	logic [IDX_W-1:0]         wr_idx;
	logic [IDX_W-1:0]         rd_idx;

	// address and data accepted together, not while a response is pending
	assign awready_o = awvalid_i && wvalid_i && !bvalid_o;
	assign wready_o  = awvalid_i && wvalid_i && !bvalid_o;
	assign arready_o = arvalid_i && !rvalid_o;

	assign wr_hs = awvalid_i && awready_o;
	assign rd_hs = arvalid_i && arready_o;

	assign wr_in_range = awaddr_i[`LSU_ADDR_LEN-1:2] < (`LSU_ADDR_LEN-2)'(`LSU_MEM_WORDS);
	assign rd_in_range = araddr_i[`LSU_ADDR_LEN-1:2] < (`LSU_ADDR_LEN-2)'(`LSU_MEM_WORDS);
	assign wr_idx      = awaddr_i[IDX_W+1:2];
	assign rd_idx      = araddr_i[IDX_W+1:2];

	always_ff @(posedge clock) begin
		if (wr_hs && wr_in_range) begin
			for (int b = 0; b < `LSU_STRB_LEN; b++) begin
				if (wstrb_i[b]) begin
					mem_q[wr_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
				end
			end
		end
	end

	// write response
	always_ff @(posedge clock) begin
		if (!rstn) begin
			bvalid_o <= 1'b0;
		end else if (wr_hs) begin
			bvalid_o <= 1'b1;
		end else if (bready_i) begin
			bvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_hs) begin
			if (wr_in_range) begin
				bresp_o <= lsu_pkg::OKAY;
			end else begin
				bresp_o <= lsu_pkg::SLVERR;
			end
		end
	end

	// read data, one cycle after the address
	always_ff @(posedge clock) begin
		if (!rstn) begin
			rvalid_o <= 1'b0;
		end else if (rd_hs) begin
			rvalid_o <= 1'b1;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_hs) begin
			if (rd_in_range) begin
				rdata_o <= mem_q[rd_idx];
				rresp_o <= lsu_pkg::OKAY;
			end else begin
				rdata_o <= '0;           // nothing behind this address
				rresp_o <= lsu_pkg::SLVERR;
			end
		end
	end

	a_b_after_write: assert property (@(posedge clock) disable iff (!rstn)
		$rose(bvalid_o) |-> $past(awvalid_i && awready_o && wvalid_i && wready_o));

endmodule

// ==== source/hold_slice.sv ====
// one-entry valid/ready register slice with a type-parameter payload
`timescale 1ns/1ns

module hold_slice #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rstn,

	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  payload_t in_data_i,

	output logic     out_valid_o,
	input  logic     out_ready_i,
	output payload_t out_data_o
);

	logic     full_q;
	payload_t data_q;
	logic     in_hs;

	// free slot, or the held item leaves this cycle
	assign in_ready_o = !full_q || out_ready_i;
	assign in_hs      = in_valid_i && in_ready_o;

	assign out_valid_o = full_q;
	assign out_data_o  = data_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			full_q <= 1'b0;
		end else if (in_hs) begin
			full_q <= 1'b1;       // refill, possibly in the same cycle as a drain
		end else if (out_ready_i) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (in_hs) begin
			data_q <= in_data_i;
		end
	end

	// a stalled output must not change under the consumer
	a_out_stable: assert property (@(posedge clock) disable iff (!rstn)
		out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

// ==== source/load_align.sv ====
// byte shift of a read word and sign or zero extension by load type
`timescale 1ns/1ns
`include "lsu_defines.svh"

module load_align (
	input  logic [`LSU_DATA_LEN-1:0] word_i,
	input  logic [1:0]               offs_i,
	input  lsu_pkg::load_type_e      load_i,
	output logic [`LSU_DATA_LEN-1:0] data_o
);

	logic [`LSU_DATA_LEN-1:0] shifted;

	// addressed byte lands in bits 7:0
	assign shifted = word_i >> {offs_i, 3'b000};

	always_comb begin
		case (load_i)
			lsu_pkg::LB: begin
				data_o = {{24{shifted[7]}}, shifted[7:0]};
			end
			lsu_pkg::LH: begin
				data_o = {{16{shifted[15]}}, shifted[15:0]};
			end
			lsu_pkg::LBU: begin
				data_o = {24'b0, shifted[7:0]};
			end
			lsu_pkg::LHU: begin
				data_o = {16'b0, shifted[15:0]};
			end
			default: begin
				data_o = shifted;      // lw, offset is zero here
			end
		endcase
	end

endmodule

// ==== source/lsu_axi_master.sv ====
// load/store FSM, store strobe and data shift, AXI4-Lite master channels
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_axi_master (
	input  logic                     clock,
	input  logic                     rstn,

	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  lsu_pkg::lsu_req_t        req_i,

	output logic [`LSU_ADDR_LEN-1:0] awaddr_o,
	output logic                     awvalid_o,
	input  logic                     awready_i,

	output logic [`LSU_DATA_LEN-1:0] wdata_o,
	output logic [`LSU_STRB_LEN-1:0] wstrb_o,
	output logic                     wvalid_o,
	input  logic                     wready_i,

	input  lsu_pkg::axi_resp_e       bresp_i,
	input  logic                     bvalid_i,
	output logic                     bready_o,

	output logic [`LSU_ADDR_LEN-1:0] araddr_o,
	output logic                     arvalid_o,
	input  logic                     arready_i,

	input  logic [`LSU_DATA_LEN-1:0] rdata_i,
	input  lsu_pkg::axi_resp_e       rresp_i,
	input  logic                     rvalid_i,
	output logic                     rready_o,

	output logic [`LSU_DATA_LEN-1:0] rword_o,
	output logic [1:0]               roffs_o,
	output lsu_pkg::load_type_e      rload_o,
	input  logic [`LSU_DATA_LEN-1:0] aligned_i,

	output logic                     res_valid_o,
	input  logic                     res_ready_i,
	output lsu_pkg::wb_result_t      res_o
);

	typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_e;

	state_e                   state_q;
	state_e                   state_d;
	lsu_pkg::lsu_req_t        req_q;
	logic                     is_load;
	logic                     is_store;
	logic                     req_hs;
	logic                     aw_hs;
	logic                     w_hs;
	logic                     b_hs;
	logic                     r_hs;
	logic                     aw_done_q;
	logic                     w_done_q;
	logic [`LSU_STRB_LEN-1:0] strb_base;
	logic [`LSU_DATA_LEN-1:0] res_data_q;
	logic                     res_err_q;

	assign is_load  = (req_q.load != lsu_pkg::LOAD_NONE);
	assign is_store = (req_q.store != lsu_pkg::STORE_NONE);

	assign req_hs = req_valid_i && req_ready_o;
	assign aw_hs  = awvalid_o && awready_i;
	assign w_hs   = wvalid_o && wready_i;
	assign b_hs   = bvalid_i && bready_o;
	assign r_hs   = rvalid_i && rready_o;

	assign req_ready_o = (state_q == IDLE);
	assign awvalid_o   = (state_q == ADDR) && is_store && !aw_done_q;
	assign wvalid_o    = (state_q == ADDR) && is_store && !w_done_q;
	assign bready_o    = (state_q == RESP) && is_store;
	assign arvalid_o   = (state_q == ADDR) && is_load;
	assign rready_o    = (state_q == RESP) && is_load;
	assign res_valid_o = (state_q == DONE);

	assign awaddr_o = req_q.addr;
	assign araddr_o = req_q.addr;

	// byte lanes before the offset shift
	always_comb begin
		case (req_q.store)
			lsu_pkg::SB: strb_base = 4'b0001;
			lsu_pkg::SH: strb_base = 4'b0011;
			lsu_pkg::SW: strb_base = 4'b1111;
			default:     strb_base = 4'b0000;
		endcase
	end

	assign wstrb_o = strb_base << req_q.addr[1:0];
	assign wdata_o = req_q.wdata << {req_q.addr[1:0], 3'b000};

	// read word goes out to the aligner, comes back in aligned_i
	assign rword_o = rdata_i;
	assign roffs_o = req_q.addr[1:0];
	assign rload_o = req_q.load;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (req_hs) begin
					if (req_i.load != lsu_pkg::LOAD_NONE || req_i.store != lsu_pkg::STORE_NONE) begin
						state_d = ADDR;
					end else begin
						state_d = DONE;   // alu result only
					end
				end
			end
			ADDR: begin
				if (is_load) begin
					if (arvalid_o && arready_i) begin
						state_d = RESP;
					end
				end else if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
					state_d = RESP;       // aw and w may finish on different cycles
				end
			end
			RESP: begin
				if (r_hs || b_hs) begin
					state_d = DONE;
				end
			end
			DONE: begin
				if (res_ready_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == ADDR && state_d == ADDR) begin
				aw_done_q <= aw_done_q || aw_hs;
				w_done_q  <= w_done_q || w_hs;
			end else begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req_hs) begin
			req_q      <= req_i;
			res_data_q <= req_i.addr;   // kept unless a bus reply overwrites it
			res_err_q  <= 1'b0;
		end else if (r_hs) begin
			res_data_q <= aligned_i;
			res_err_q  <= (rresp_i != lsu_pkg::OKAY);
		end else if (b_hs) begin
			res_data_q <= '0;
			res_err_q  <= (bresp_i != lsu_pkg::OKAY);
		end
	end

	assign res_o = '{rd: req_q.rd, data: res_data_q, err: res_err_q, mem: is_load || is_store};

	// halfwords on even addresses, words on multiples of four
	a_natural_align: assert property (@(posedge clock) disable iff (!rstn)
		req_hs |-> !((req_i.load inside {lsu_pkg::LH, lsu_pkg::LHU} || req_i.store == lsu_pkg::SH)
			&& req_i.addr[0]) && !((req_i.load == lsu_pkg::LW || req_i.store == lsu_pkg::SW)
			&& req_i.addr[1:0] != 2'b00));

	a_load_xor_store: assert property (@(posedge clock) disable iff (!rstn)
		req_hs |-> !(req_i.load != lsu_pkg::LOAD_NONE && req_i.store != lsu_pkg::STORE_NONE));

endmodule

// ==== source/lsu_defines.svh ====
// width and depth macros for the load/store unit and its data memory
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data word width in bits
`define LSU_DATA_LEN 32

// byte address width in bits
`define LSU_ADDR_LEN 32

// one strobe bit per data byte
`define LSU_STRB_LEN (`LSU_DATA_LEN / 8)

// register file index width
`define LSU_RD_LEN 5

// memory size in words, bytes at or past 4x this answer SLVERR
`define LSU_MEM_WORDS 256

`endif

// ==== source/lsu_pkg.sv ====
// load, store and response encodings plus the request and writeback payload structs
`include "lsu_defines.svh"

package lsu_pkg;

	// funct3 style load kinds, zero means no load
	typedef enum logic [2:0] {
		LOAD_NONE,
		LB,
		LH,
		LW,
		LBU,
		LHU
	} load_type_e;

	typedef enum logic [1:0] {
		STORE_NONE,
		SB,
		SH,
		SW
	} store_type_e;

	// only the two answers the memory gives
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	typedef struct packed {
		load_type_e               load;
		store_type_e              store;
		logic [`LSU_ADDR_LEN-1:0] addr;   // alu result
		logic [`LSU_DATA_LEN-1:0] wdata;
		logic [`LSU_RD_LEN-1:0]   rd;
	} lsu_req_t;

	typedef struct packed {
		logic [`LSU_RD_LEN-1:0]   rd;
		logic [`LSU_DATA_LEN-1:0] data;
		logic                     err;    // bus error on this access
		logic                     mem;    // was a load or store
	} wb_result_t;

endpackage

// ==== source/lsu_top.sv ====
// load/store unit top with request and writeback slices, AXI4-Lite master and data memory
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_top (
	input  logic                     clock,
	input  logic                     rstn,

	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  lsu_pkg::load_type_e      req_load_i,
	input  lsu_pkg::store_type_e     req_store_i,
	input  logic [`LSU_ADDR_LEN-1:0] req_addr_i,
	input  logic [`LSU_DATA_LEN-1:0] req_wdata_i,
	input  logic [`LSU_RD_LEN-1:0]   req_rd_i,

	output logic                     wb_valid_o,
	input  logic                     wb_ready_i,
	output logic [`LSU_RD_LEN-1:0]   wb_rd_o,
	output logic [`LSU_DATA_LEN-1:0] wb_data_o,
	output logic                     wb_err_o,
	output logic                     wb_mem_o
);

	lsu_pkg::lsu_req_t        req_in;
	lsu_pkg::lsu_req_t        req_q;
	logic                     req_q_valid;
	logic                     req_q_ready;
	lsu_pkg::wb_result_t      res;
	logic                     res_valid;
	logic                     res_ready;
	lsu_pkg::wb_result_t      wb_out;

	logic [`LSU_ADDR_LEN-1:0] awaddr;
	logic                     awvalid;
	logic                     awready;
	logic [`LSU_DATA_LEN-1:0] wdata;
	logic [`LSU_STRB_LEN-1:0] wstrb;
	logic                     wvalid;
	logic                     wready;
	lsu_pkg::axi_resp_e       bresp;
	logic                     bvalid;
	logic                     bready;
	logic [`LSU_ADDR_LEN-1:0] araddr;
	logic                     arvalid;
	logic                     arready;
	logic [`LSU_DATA_LEN-1:0] rdata;
	lsu_pkg::axi_resp_e       rresp;
	logic                     rvalid;
	logic                     rready;

	logic [`LSU_DATA_LEN-1:0] rword;
	logic [1:0]               roffs;
	lsu_pkg::load_type_e      rload;
	logic [`LSU_DATA_LEN-1:0] aligned;

	assign req_in = '{load: req_load_i, store: req_store_i, addr: req_addr_i,
		wdata: req_wdata_i, rd: req_rd_i};

	hold_slice #(.payload_t(lsu_pkg::lsu_req_t)) u_req_slice (
		.clock(clock), .rstn(rstn),
		.in_valid_i(req_valid_i), .in_ready_o(req_ready_o), .in_data_i(req_in),
		.out_valid_o(req_q_valid), .out_ready_i(req_q_ready), .out_data_o(req_q)
	);

	lsu_axi_master u_master (
		.clock(clock), .rstn(rstn),
		.req_valid_i(req_q_valid), .req_ready_o(req_q_ready), .req_i(req_q),
		.awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
		.wdata_o(wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
		.bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready),
		.araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
		.rdata_i(rdata), .rresp_i(rresp), .rvalid_i(rvalid), .rready_o(rready),
		.rword_o(rword), .roffs_o(roffs), .rload_o(rload), .aligned_i(aligned),
		.res_valid_o(res_valid), .res_ready_i(res_ready), .res_o(res)
	);

	load_align u_load_align (
		.word_i(rword), .offs_i(roffs), .load_i(rload), .data_o(aligned)
	);

	data_ram_axil u_data_ram (
		.clock(clock), .rstn(rstn),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
		.wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
		.bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
		.araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
		.rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready)
	);

	hold_slice #(.payload_t(lsu_pkg::wb_result_t)) u_wb_slice (
		.clock(clock), .rstn(rstn),
		.in_valid_i(res_valid), .in_ready_o(res_ready), .in_data_i(res),
		.out_valid_o(wb_valid_o), .out_ready_i(wb_ready_i), .out_data_o(wb_out)
	);

	// writeback fields back to loose ports
	assign wb_rd_o   = wb_out.rd;
	assign wb_data_o = wb_out.data;
	assign wb_err_o  = wb_out.err;
	assign wb_mem_o  = wb_out.mem;

endmodule

// ==== sources.f ====
+incdir+source
source/lsu_pkg.sv
source/hold_slice.sv
source/load_align.sv
source/lsu_axi_master.sv
source/data_ram_axil.sv
source/lsu_top.sv
verif/lsu_tb.sv

// ==== verif/lsu_tb.sv ====
// testbench for lsu_top with a stimulus table, byte reference memory and random writeback stall
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_tb;

	localparam int MEM_BYTES = `LSU_MEM_WORDS * 4;

	logic                     clock;
	logic                     rstn;
	logic                     req_valid;
	logic                     req_ready;
	lsu_pkg::load_type_e      req_load;
	lsu_pkg::store_type_e     req_store;
	logic [`LSU_ADDR_LEN-1:0] req_addr;
	logic [`LSU_DATA_LEN-1:0] req_wdata;
	logic [`LSU_RD_LEN-1:0]   req_rd;
	logic                     wb_valid;
	logic                     wb_ready;
	logic [`LSU_RD_LEN-1:0]   wb_rd;
	logic [`LSU_DATA_LEN-1:0] wb_data;
	logic                     wb_err;
	logic                     wb_mem;

	lsu_pkg::lsu_req_t        rows[$];      // stimulus table
	lsu_pkg::wb_result_t      exp_q[$];     // expected result per row
	logic [7:0]               ref_mem [MEM_BYTES];
	logic [31:0]              lfsr;
	int                       n_done = 0;
	int                       cycles = 0;
	int                       cycle_limit = 0;

	lsu_top u_dut (
		.clock(clock), .rstn(rstn),
		.req_valid_i(req_valid), .req_ready_o(req_ready), .req_load_i(req_load),
		.req_store_i(req_store), .req_addr_i(req_addr), .req_wdata_i(req_wdata),
		.req_rd_i(req_rd),
		.wb_valid_o(wb_valid), .wb_ready_i(wb_ready), .wb_rd_o(wb_rd),
		.wb_data_o(wb_data), .wb_err_o(wb_err), .wb_mem_o(wb_mem)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	task automatic stop_on_error();
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string what, input logic [`LSU_DATA_LEN-1:0] got,
		input logic [`LSU_DATA_LEN-1:0] exp);
		if (got !== exp) begin
			$display("ERROR @%0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		if (got != exp) begin
			$display("ERROR @%0t ns: %s is %0b, expected %0b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_rd(input string what, input logic [`LSU_RD_LEN-1:0] got,
		input logic [`LSU_RD_LEN-1:0] exp);
		if (got !== exp) begin
			$display("ERROR @%0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	// 32-bit fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic bit take_random_bit();
		bit fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// expected result of one row and the byte model update for stores
	function automatic lsu_pkg::wb_result_t model_row(input lsu_pkg::lsu_req_t r);
		lsu_pkg::wb_result_t e;
		int                  nbytes;
		int                  i;
		e = '{rd: r.rd, data: r.addr, err: 1'b0, mem: 1'b1};
		if (r.load == lsu_pkg::LOAD_NONE && r.store == lsu_pkg::STORE_NONE) begin
			e.mem = 1'b0;                  // alu result passes through
		end else if (r.addr >= MEM_BYTES) begin
			e.data = '0;
			e.err  = 1'b1;
		end else if (r.store != lsu_pkg::STORE_NONE) begin
			e.data = '0;
			nbytes = (r.store == lsu_pkg::SB) ? 1 : (r.store == lsu_pkg::SH) ? 2 : 4;
			for (i = 0; i < nbytes; i++) begin
				ref_mem[r.addr + i] = r.wdata[i*8 +: 8];
			end
		end else begin
			nbytes = (r.load inside {lsu_pkg::LB, lsu_pkg::LBU}) ? 1 :
				(r.load inside {lsu_pkg::LH, lsu_pkg::LHU}) ? 2 : 4;
			e.data = '0;
			for (i = 0; i < nbytes; i++) begin
				e.data[i*8 +: 8] = ref_mem[r.addr + i];
			end
			if (r.load inside {lsu_pkg::LB, lsu_pkg::LH} && e.data[nbytes*8-1]) begin
				for (i = nbytes * 8; i < `LSU_DATA_LEN; i++) begin
					e.data[i] = 1'b1;
				end
			end
		end
		return e;
	endfunction

	task automatic add_row(input lsu_pkg::load_type_e ld, input lsu_pkg::store_type_e st,
		input logic [`LSU_ADDR_LEN-1:0] addr, input logic [`LSU_DATA_LEN-1:0] wdata);
		lsu_pkg::lsu_req_t r;
		r = '{load: ld, store: st, addr: addr, wdata: wdata,
			rd: (`LSU_RD_LEN)'(rows.size() * 7 + 3)};
		rows.push_back(r);
		exp_q.push_back(model_row(r));
	endtask

	task automatic build_table();
		int i;
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'h1234_5678, 32'h0);
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'hdead_beef, 32'h0);
		// word, half and byte stores each read back whole
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SW, 32'h10, 32'h1122_3344);
		add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h10, 32'h0);
		for (i = 0; i < 4; i += 2) begin
			add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SH, 32'h10 + i, 32'hbeef_a5c0 + i);
			add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h10, 32'h0);
		end
		for (i = 0; i < 4; i++) begin
			add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SB, 32'h10 + i, 32'hdead_be90 + i);
			add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h10, 32'h0);
		end
		// top bit set in every byte
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SW, 32'h20, 32'h8f9e_adbc);
		for (i = 0; i < 4; i++) begin
			add_row(lsu_pkg::LB, lsu_pkg::STORE_NONE, 32'h20 + i, 32'h0);
			add_row(lsu_pkg::LBU, lsu_pkg::STORE_NONE, 32'h20 + i, 32'h0);
		end
		for (i = 0; i < 4; i += 2) begin
			add_row(lsu_pkg::LH, lsu_pkg::STORE_NONE, 32'h20 + i, 32'h0);
			add_row(lsu_pkg::LHU, lsu_pkg::STORE_NONE, 32'h20 + i, 32'h0);
		end
		// last word in range then accesses that alias words 0x10 and 0x20
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SW, 32'h3fc, 32'hc3c3_5a5a);
		add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h3fc, 32'h0);
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SW, 32'h410, 32'h5555_5555);
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::SB, 32'h423, 32'h0000_0077);
		add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h400, 32'h0);
		add_row(lsu_pkg::LBU, lsu_pkg::STORE_NONE, 32'h8000_0001, 32'h0);
		add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h10, 32'h0);
		add_row(lsu_pkg::LW, lsu_pkg::STORE_NONE, 32'h20, 32'h0);
		add_row(lsu_pkg::LOAD_NONE, lsu_pkg::STORE_NONE, 32'h0000_0abc, 32'h0);
	endtask

	// random writeback stall
	always @(posedge clock) begin
		wb_ready <= take_random_bit();
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d of %0d results back",
				cycles, n_done, exp_q.size());
			stop_on_error();
		end
	end

	// handshake seen at negedge completes on the next posedge
	always @(negedge clock) begin
		if (rstn && wb_valid && wb_ready) begin
			if (n_done >= exp_q.size()) begin
				$display("an extra writeback result came after all %0d rows", exp_q.size());
				stop_on_error();
			end else begin
				check_rd($sformatf("row %0d rd", n_done), wb_rd, exp_q[n_done].rd);
				check_word($sformatf("row %0d data", n_done), wb_data, exp_q[n_done].data);
				check_flag($sformatf("row %0d err", n_done), wb_err, exp_q[n_done].err);
				check_flag($sformatf("row %0d mem", n_done), wb_mem, exp_q[n_done].mem);
				n_done++;
			end
		end
	end

	initial begin
		int k;
		rstn      = 1'b0;
		req_valid = 1'b0;
		req_load  = lsu_pkg::LOAD_NONE;
		req_store = lsu_pkg::STORE_NONE;
		req_addr  = '0;
		req_wdata = '0;
		req_rd    = '0;
		wb_ready  = 1'b0;
		lfsr      = 32'hf6de;
		build_table();
		cycle_limit = 40 * rows.size();
		repeat (9) @(posedge clock);
		@(negedge clock);
		check_flag("req_ready in reset", req_ready, 1'b1);
		check_flag("wb_valid in reset", wb_valid, 1'b0);
		@(posedge clock);
		rstn <= 1'b1;
		for (k = 0; k < rows.size(); k++) begin
			req_valid <= 1'b1;
			req_load  <= rows[k].load;
			req_store <= rows[k].store;
			req_addr  <= rows[k].addr;
			req_wdata <= rows[k].wdata;
			req_rd    <= rows[k].rd;
			@(negedge clock);
			while (!req_ready) begin
				@(negedge clock);
			end
			@(posedge clock);
		end
		req_valid <= 1'b0;
		wait (n_done == rows.size());
		repeat (20) @(posedge clock);   // window for a duplicated result
		$display(">>> PASS");
		$finish;
	end

endmodule
